/* sources.f */
logic/ipv4_pkg.sv
logic/ipv4_tx_if.sv
logic/ipv4_chsum.sv
logic/ipv4_rx.sv
logic/ipv4_tx.sv
logic/ipv4_tx_arb.sv
logic/ipv4_layer_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* Makefile */
SRCS := $(shell cat sources.f)

build/Vtb_top: $(SRCS) sources.f
	verilator --binary --timing --assert --top-module tb_top -Mdir build -o Vtb_top -f sources.f

.PHONY: run clean

run: build/Vtb_top
	./build/Vtb_top | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf build sim.log

/* dv/tb_top.sv */
module tb_top import ipv4_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam ipv4_t DEV_IP = 32'hC0A8_0010;
  localparam ipv4_t BAD_IP = 32'h0A00_00EE;  // ARP table has no entry for this one
  localparam int LIMIT = 1000;

  logic clk = 1'b0;
  logic fsm_rst;
  logic [7:0] mac_rx_dat;
  logic mac_rx_val, mac_rx_sof, mac_rx_eof, mac_rx_err;
  logic [15:0] mac_rx_ethertype;
  ipv4_t dev_ipv4;
  logic [7:0] rx_dat;
  logic rx_val, rx_sof, rx_eof, rx_err;
  ipv4_t rx_src_ip;
  proto_t rx_proto;
  length_t rx_payload_len;
  logic [N_CLIENT-1:0] cl_rdy, cl_val, cl_eof, cl_broadcast, cl_req, cl_done;
  logic [N_CLIENT-1:0][7:0] cl_dat;
  ipv4_t [N_CLIENT-1:0] cl_dst_ip;
  proto_t [N_CLIENT-1:0] cl_proto;
  length_t [N_CLIENT-1:0] cl_payload_len;
  ipv4_t arp_ipv4_req;
  mac_addr_t arp_mac_rsp;
  logic arp_val, arp_err;
  logic [7:0] mac_tx_dat;
  logic mac_tx_val, mac_tx_sof, mac_tx_eof;
  mac_addr_t mac_tx_dst_mac;

  int n_timeout = 0;
  int n_pkts = 0;
  int n_sent = 0;

  always #2 clk = ~clk;

  ipv4_layer_top uut (.*);

  tb_checker chk (.*);

  // ARP table model
  initial begin
    int d;
    forever begin
      @(negedge clk);
      if (!fsm_rst && arp_ipv4_req != '0) begin
        d = 2 + int'($urandom % 9);
        repeat (d - 1) @(negedge clk);
        if (arp_ipv4_req == BAD_IP) arp_err = 1'b1;
        else begin
          arp_val = 1'b1;
          arp_mac_rsp = chk.arp_mac(arp_ipv4_req);
        end
        @(negedge clk);
        arp_val = 1'b0;
        arp_err = 1'b0;
      end
    end
  end

  function automatic ipv4_t rnd_ip();
    ipv4_t ip;
    ip = $urandom;
    if (ip == '0 || ip == BAD_IP || ip == '1) ip = 32'h0A00_0001;
    return ip;
  endfunction

  task automatic run_client(input int i, input ipv4_t dst, input logic bc, input int len);
    int t;
    logic got_req, got_done;
    logic [7:0] p;
    case ($urandom % 4)
      0: p = 8'd1;
      1: p = 8'd6;
      2: p = 8'd17;
      default: p = 8'd99;
    endcase
    cl_dst_ip[i] = dst;
    cl_proto[i] = proto_t'(p);
    cl_payload_len[i] = length_t'(len);
    cl_broadcast[i] = bc;
    cl_rdy[i] = 1'b1;
    n_pkts++;
    t = 0;
    got_req = 1'b0;
    got_done = 1'b0;
    while (!got_req && !got_done && t < LIMIT) begin
      @(negedge clk);
      got_req = cl_req[i];
      got_done = cl_done[i];
      t++;
    end
    if (got_req) begin
      for (int k = 0; k < len; k++) begin
        cl_val[i] = 1'b1;
        cl_dat[i] = 8'($urandom);
        cl_eof[i] = (k == len - 1);
        @(negedge clk);
      end
      cl_val[i] = 1'b0;
      cl_eof[i] = 1'b0;
      t = 0;
      while (!got_done && t < LIMIT) begin
        @(negedge clk);
        got_done = cl_done[i];
        t++;
      end
    end
    if (!got_done) begin
      $display("Timeout: client %0d never saw its cl_done", i);
      n_timeout++;
    end
    cl_rdy[i] = 1'b0;
  endtask

  task automatic send_rx(input logic [15:0] ety, input logic [7:0] vihl, input ipv4_t dst,
                         input int len, input logic bad, input int err_at);
    logic [159:0] h;
    int tot;
    tot = len + 20;
    h = {vihl, 8'h00, 16'(tot), 16'($urandom), 8'h40, 8'h00, 8'd64, 8'd17, 16'h0000,
         rnd_ip(), dst};
    h[79:64] = ~chk.ip_sum(h);
    if (bad) h[79:64] = h[79:64] ^ 16'h0001;
    mac_rx_ethertype = ety;
    for (int k = 0; k < tot; k++) begin
      mac_rx_val = 1'b1;
      mac_rx_sof = (k == 0);
      mac_rx_eof = (k == tot - 1);
      mac_rx_err = (k == err_at);
      mac_rx_dat = (k < 20) ? h[159-8*k -: 8] : 8'($urandom);
      @(negedge clk);
    end
    mac_rx_val = 1'b0;
    mac_rx_sof = 1'b0;
    mac_rx_eof = 1'b0;
    mac_rx_err = 1'b0;
    repeat (3) @(negedge clk);  // Inter-frame gap
  endtask

  initial begin
    int t;
    void'($urandom(32'h45e1));
    fsm_rst = 1'b1;
    dev_ipv4 = DEV_IP;
    mac_rx_dat = '0;
    mac_rx_val = 1'b0;
    mac_rx_sof = 1'b0;
    mac_rx_eof = 1'b0;
    mac_rx_err = 1'b0;
    mac_rx_ethertype = '0;
    cl_rdy = '0;
    cl_dat = '0;
    cl_val = '0;
    cl_eof = '0;
    cl_dst_ip = '0;
    cl_proto = '0;
    cl_payload_len = '0;
    cl_broadcast = '0;
    arp_mac_rsp = '0;
    arp_val = 1'b0;
    arp_err = 1'b0;
    repeat (10) @(negedge clk);
    fsm_rst = 1'b0;

    // One unicast client at a time
    for (int n = 0; n < 4; n++) begin
      run_client(int'($urandom % 3), rnd_ip(), 1'b0, 1 + int'($urandom % 40));
      n_sent++;
    end
    // Broadcast skips ARP
    for (int n = 0; n < 2; n++) begin
      run_client(int'($urandom % 3), '1, 1'b1, 1 + int'($urandom % 40));
      n_sent++;
    end
    // All three clients at once
    fork
      run_client(0, rnd_ip(), 1'b0, 1 + int'($urandom % 40));
      run_client(1, rnd_ip(), 1'b0, 1 + int'($urandom % 40));
      run_client(2, rnd_ip(), 1'b1, 1 + int'($urandom % 40));
    join
    n_sent += 3;
    // ARP failure followed by one normal frame
    run_client(0, BAD_IP, 1'b0, 8);
    run_client(1, rnd_ip(), 1'b0, 1 + int'($urandom % 40));
    n_sent++;

    // Receive filtering
    send_rx(16'h0800, 8'h45, DEV_IP, 1 + int'($urandom % 40), 1'b0, -1);
    send_rx(16'h0800, 8'h45, '1, 1 + int'($urandom % 40), 1'b0, -1);
    send_rx(16'h0800, 8'h45, DEV_IP, 12, 1'b1, -1);
    send_rx(16'h0800, 8'h45, rnd_ip(), 12, 1'b0, -1);
    send_rx(16'h86DD, 8'h45, DEV_IP, 12, 1'b0, -1);
    send_rx(16'h0800, 8'h46, DEV_IP, 12, 1'b0, -1);
    // Error inside an accepted payload followed by a clean packet
    send_rx(16'h0800, 8'h45, DEV_IP, 16, 1'b0, 25);
    send_rx(16'h0800, 8'h45, DEV_IP, 1 + int'($urandom % 40), 1'b0, -1);

    t = 0;
    while ((chk.rx_q.size() != 0 || chk.tx_open) && t < LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (t >= LIMIT) begin
      $display("Timeout: expected outputs never drained");
      n_timeout++;
    end
    chk.compare_counts(n_sent, n_pkts);
    $display("Errors: checker %0d, timeouts %0d", chk.n_err, n_timeout);
    if (chk.n_err == 0 && n_timeout == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dv/tb_checker.sv */
module tb_checker import ipv4_pkg::*; (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  ipv4_t                        dev_ipv4,
  input  logic    [7:0]                mac_rx_dat,
  input  logic                         mac_rx_val,
  input  logic                         mac_rx_sof,
  input  logic                         mac_rx_err,
  input  logic    [15:0]               mac_rx_ethertype,
  input  logic    [7:0]                rx_dat,
  input  logic                         rx_val,
  input  logic                         rx_sof,
  input  logic                         rx_eof,
  input  logic                         rx_err,
  input  ipv4_t                        rx_src_ip,
  input  proto_t                       rx_proto,
  input  length_t                      rx_payload_len,
  input  logic    [N_CLIENT-1:0]       cl_rdy,
  input  logic    [N_CLIENT-1:0][7:0]  cl_dat,
  input  logic    [N_CLIENT-1:0]       cl_val,
  input  ipv4_t   [N_CLIENT-1:0]       cl_dst_ip,
  input  proto_t  [N_CLIENT-1:0]       cl_proto,
  input  length_t [N_CLIENT-1:0]       cl_payload_len,
  input  logic    [N_CLIENT-1:0]       cl_broadcast,
  input  logic    [N_CLIENT-1:0]       cl_req,
  input  logic    [N_CLIENT-1:0]       cl_done,
  input  ipv4_t                        arp_ipv4_req,
  input  logic    [7:0]                mac_tx_dat,
  input  logic                         mac_tx_val,
  input  logic                         mac_tx_sof,
  input  logic                         mac_tx_eof,
  input  mac_addr_t                    mac_tx_dst_mac
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic       err;
    logic       sof;
    logic       eof;
    logic [7:0] dat;
    ipv4_t      src;
    logic [7:0] proto;
    length_t    len;
  } rx_ev_t;

  int n_err = 0;
  int n_frame = 0;
  int n_done = 0;
  int n_req = 0;
  rx_ev_t rx_q[$];          // Expected receive outputs in order
  logic [7:0] exp_frm[$];
  logic [7:0] act_frm[$];
  logic tx_open = 1'b0;     // Open from cl_req until the frame ends
  int owner = 0;
  mac_addr_t exp_mac;
  logic [15:0] exp_id = '0;
  logic [N_CLIENT-1:0] rdy_s = '0;
  logic [159:0] rhdr;       // Byte 0 of the header in the top bits
  int rcnt = 0;
  int rtot = 0;
  logic [15:0] rety;
  logic rlive = 1'b0;

  // Ones' complement sum over the ten header words
  function automatic logic [15:0] ip_sum(input logic [159:0] h);
    logic [31:0] s;
    s = '0;
    for (int w = 0; w < 10; w++) s = s + {16'h0, h[159-16*w -: 16]};
    s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
    s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
    return s[15:0];
  endfunction

  function automatic logic [159:0] tx_hdr(input logic [15:0] id, input length_t len,
                                          input logic [7:0] proto, input ipv4_t src,
                                          input ipv4_t dst);
    logic [159:0] h;
    h = {8'h45, 8'h00, len + 16'd20, id, 8'h40, 8'h00, 8'd64, proto, 16'h0000, src, dst};
    h[79:64] = ~ip_sum(h);
    return h;
  endfunction

  // MAC that the ARP table model returns for an address
  function automatic mac_addr_t arp_mac(input ipv4_t ip);
    return {16'h02AA, ip ^ 32'h5A5A_5A5A};
  endfunction

  task automatic close_frame();
    if (!tx_open) begin
      $display("Frame left the MAC port without any cl_req");
      n_err++;
    end else begin
      if (act_frm.size() != exp_frm.size()) begin
        $display("FAIL mac_tx length: expected %h, got %h", exp_frm.size(), act_frm.size());
        n_err++;
      end else begin
        for (int k = 0; k < act_frm.size(); k++) begin
          if (act_frm[k] !== exp_frm[k]) begin
            $display("FAIL mac_tx_dat byte %0d: expected %h, got %h", k, exp_frm[k], act_frm[k]);
            n_err++;
          end
        end
      end
      if (mac_tx_dst_mac !== exp_mac) begin
        $display("FAIL mac_tx_dst_mac: expected %h, got %h", exp_mac, mac_tx_dst_mac);
        n_err++;
      end
      n_frame++;
    end
    tx_open = 1'b0;
    act_frm.delete();
  endtask

  // End-of-run totals against what the stimulus issued
  task automatic compare_counts(input int sent, input int pkts);
    if (n_req != sent) begin
      $display("FAIL cl_req count: expected %h, got %h", sent, n_req);
      n_err++;
    end
    if (n_frame != sent) begin
      $display("FAIL mac_tx frame count: expected %h, got %h", sent, n_frame);
      n_err++;
    end
    if (n_done != pkts) begin
      $display("FAIL cl_done count: expected %h, got %h", pkts, n_done);
      n_err++;
    end
  endtask

  // Inputs driven by the testbench are sampled on the rising edge
  always @(posedge clk) begin
    rdy_s <= cl_rdy;
    if (tx_open && cl_val[owner]) exp_frm.push_back(cl_dat[owner]);
    if (mac_rx_val && !fsm_rst) begin
      if (mac_rx_sof) begin
        rcnt = 0;
        rety = mac_rx_ethertype;
        rlive = 1'b0;
      end
      if (rcnt < 20) rhdr = {rhdr[151:0], mac_rx_dat};
      if (rcnt == 19) begin
        rtot = int'(rhdr[143:128]);
        rlive = (rety == 16'h0800) && (rhdr[159:152] == 8'h45) &&
                (ip_sum(rhdr) == 16'hFFFF) && (rtot > 20) &&
                ((rhdr[31:0] == dev_ipv4) || (rhdr[31:0] == 32'hFFFF_FFFF));
      end else if (rcnt >= 20 && rlive && rcnt < rtot) begin
        rx_q.push_back('{err: mac_rx_err, sof: rcnt == 20, eof: rcnt == rtot - 1,
                         dat: mac_rx_dat, src: rhdr[63:32], proto: rhdr[87:80],
                         len: 16'(rtot - 20)});
        if (mac_rx_err) rlive = 1'b0;  // Rest of the packet is lost
      end
      rcnt++;
    end
  end

  // DUT outputs are checked on the falling edge
  always @(negedge clk) begin
    rx_ev_t e;
    int idx;
    logic [159:0] h;
    logic hit;
    if (!fsm_rst) begin
      if (arp_ipv4_req != '0) begin
        hit = 1'b0;
        for (int i = 0; i < N_CLIENT; i++) begin
          if (rdy_s[i] && !cl_broadcast[i] && cl_dst_ip[i] == arp_ipv4_req) hit = 1'b1;
        end
        if (!hit) begin
          $display("FAIL arp_ipv4_req: got %h, no waiting unicast client has it",
                   arp_ipv4_req);
          n_err++;
        end
      end
      if (cl_req != '0) begin
        idx = 0;
        for (int i = 0; i < N_CLIENT; i++) if (cl_req[i]) idx = i;
        if (!$onehot(cl_req)) begin
          $display("FAIL cl_req: expected one-hot, got %h", cl_req);
          n_err++;
        end
        for (int j = idx + 1; j < N_CLIENT; j++) begin
          if (rdy_s[j]) begin
            $display("Client %0d was served while higher client %0d was waiting", idx, j);
            n_err++;
          end
        end
        if (tx_open) begin
          $display("New cl_req while the previous frame was still open");
          n_err++;
        end
        h = tx_hdr(exp_id, cl_payload_len[idx], 8'(cl_proto[idx]), dev_ipv4, cl_dst_ip[idx]);
        exp_frm.delete();
        for (int k = 0; k < 20; k++) exp_frm.push_back(h[159-8*k -: 8]);
        exp_mac = cl_broadcast[idx] ? '1 : arp_mac(cl_dst_ip[idx]);
        exp_id = exp_id + 16'd1;
        owner = idx;
        tx_open = 1'b1;
        n_req++;
      end
      if (mac_tx_val) begin
        if (mac_tx_sof !== (act_frm.size() == 0)) begin
          $display("FAIL mac_tx_sof: expected %h, got %h", act_frm.size() == 0, mac_tx_sof);
          n_err++;
        end
        act_frm.push_back(mac_tx_dat);
        if (mac_tx_eof) close_frame();
      end
      n_done += $countones(cl_done);
      if (rx_val || rx_err) begin
        if (rx_q.size() == 0) begin
          $display("Receive output appeared with no payload expected");
          n_err++;
        end else begin
          e = rx_q.pop_front();
          if (rx_err !== e.err) begin
            $display("FAIL rx_err: expected %h, got %h", e.err, rx_err);
            n_err++;
          end else if (!e.err) begin
            if (rx_dat !== e.dat || rx_sof !== e.sof || rx_eof !== e.eof) begin
              $display("FAIL rx_dat/sof/eof: expected %h, got %h",
                       {e.dat, e.sof, e.eof}, {rx_dat, rx_sof, rx_eof});
              n_err++;
            end
            if (rx_src_ip !== e.src || 8'(rx_proto) !== e.proto || rx_payload_len !== e.len) begin
              $display("FAIL rx_src_ip/proto/len: expected %h, got %h",
                       {e.src, e.proto, e.len}, {rx_src_ip, 8'(rx_proto), rx_payload_len});
              n_err++;
            end
          end
        end
      end
    end
  end

endmodule

/* logic/ipv4_layer_top.sv */
module ipv4_layer_top import ipv4_pkg::*; (
  input  logic                         clk,
  input  logic                         fsm_rst,
  // MAC receive
  input  logic    [7:0]                mac_rx_dat,
  input  logic                         mac_rx_val,
  input  logic                         mac_rx_sof,
  input  logic                         mac_rx_eof,
  input  logic                         mac_rx_err,
  input  logic    [15:0]               mac_rx_ethertype,
  input  ipv4_t                        dev_ipv4,
  // Received payload
  output logic    [7:0]                rx_dat,
  output logic                         rx_val,
  output logic                         rx_sof,
  output logic                         rx_eof,
  output logic                         rx_err,
  output ipv4_t                        rx_src_ip,
  output proto_t                       rx_proto,
  output length_t                      rx_payload_len,
  // Transmit clients
  input  logic    [N_CLIENT-1:0]       cl_rdy,
  input  logic    [N_CLIENT-1:0][7:0]  cl_dat,
  input  logic    [N_CLIENT-1:0]       cl_val,
  input  logic    [N_CLIENT-1:0]       cl_eof,
  input  ipv4_t   [N_CLIENT-1:0]       cl_dst_ip,
  input  proto_t  [N_CLIENT-1:0]       cl_proto,
  input  length_t [N_CLIENT-1:0]       cl_payload_len,
  input  logic    [N_CLIENT-1:0]       cl_broadcast,
  output logic    [N_CLIENT-1:0]       cl_req,
  output logic    [N_CLIENT-1:0]       cl_done,
  // ARP table
  output ipv4_t                        arp_ipv4_req,
  input  mac_addr_t                    arp_mac_rsp,
  input  logic                         arp_val,
  input  logic                         arp_err,
  // MAC transmit
  output logic    [7:0]                mac_tx_dat,
  output logic                         mac_tx_val,
  output logic                         mac_tx_sof,
  output logic                         mac_tx_eof,
  output mac_addr_t                    mac_tx_dst_mac
);

  ipv4_tx_if tx_bus ();

  ipv4_rx u_rx (
    .clk              (clk),
    .fsm_rst          (fsm_rst),
    .dev_ipv4         (dev_ipv4),
    .mac_rx_dat       (mac_rx_dat),
    .mac_rx_val       (mac_rx_val),
    .mac_rx_sof       (mac_rx_sof),
    .mac_rx_eof       (mac_rx_eof),
    .mac_rx_err       (mac_rx_err),
    .mac_rx_ethertype (mac_rx_ethertype),
    .rx_dat           (rx_dat),
    .rx_val           (rx_val),
    .rx_sof           (rx_sof),
    .rx_eof           (rx_eof),
    .rx_err           (rx_err),
    .rx_src_ip        (rx_src_ip),
    .rx_proto         (rx_proto),
    .rx_payload_len   (rx_payload_len)
  );

  ipv4_tx_arb u_arb (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .cl_rdy         (cl_rdy),
    .cl_dat         (cl_dat),
    .cl_val         (cl_val),
    .cl_eof         (cl_eof),
    .cl_dst_ip      (cl_dst_ip),
    .cl_proto       (cl_proto),
    .cl_payload_len (cl_payload_len),
    .cl_broadcast   (cl_broadcast),
    .cl_req         (cl_req),
    .cl_done        (cl_done),
    .tx             (tx_bus)
  );

  ipv4_tx u_tx (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .dev_ipv4       (dev_ipv4),
    .tx             (tx_bus),
    .arp_ipv4_req   (arp_ipv4_req),
    .arp_mac_rsp    (arp_mac_rsp),
    .arp_val        (arp_val),
    .arp_err        (arp_err),
    .mac_tx_dat     (mac_tx_dat),
    .mac_tx_val     (mac_tx_val),
    .mac_tx_sof     (mac_tx_sof),
    .mac_tx_eof     (mac_tx_eof),
    .mac_tx_dst_mac (mac_tx_dst_mac)
  );

endmodule

/* logic/ipv4_tx_arb.sv */
module ipv4_tx_arb import ipv4_pkg::*; (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  logic    [N_CLIENT-1:0]       cl_rdy,
  input  logic    [N_CLIENT-1:0][7:0]  cl_dat,
  input  logic    [N_CLIENT-1:0]       cl_val,
  input  logic    [N_CLIENT-1:0]       cl_eof,
  input  ipv4_t   [N_CLIENT-1:0]       cl_dst_ip,
  input  proto_t  [N_CLIENT-1:0]       cl_proto,
  input  length_t [N_CLIENT-1:0]       cl_payload_len,
  input  logic    [N_CLIENT-1:0]       cl_broadcast,
  output logic    [N_CLIENT-1:0]       cl_req,
  output logic    [N_CLIENT-1:0]       cl_done,
  ipv4_tx_if.src                       tx
);

  logic [N_CLIENT-1:0] sel;   // One-hot owner of the transmitter
  logic [N_CLIENT-1:0] pick;
  logic       busy;
  logic       cool;           // Client may still show rdy right after done
  logic [7:0] mux_dat;
  ipv4_t      mux_dst;
  proto_t     mux_proto;
  length_t    mux_len;
  logic       mux_bcast;

  assign busy    = |sel;
  assign cl_req  = sel & {N_CLIENT{tx.req}};
  assign cl_done = sel & {N_CLIENT{tx.done}};

  // Highest index wins
  always_comb begin
    pick = '0;
    for (int i = 0; i < N_CLIENT; i++) begin
      if (cl_rdy[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  always_comb begin
    mux_dat   = '0;
    mux_dst   = '0;
    mux_proto = proto_t'(8'h00);
    mux_len   = '0;
    mux_bcast = 1'b0;
    for (int i = 0; i < N_CLIENT; i++) begin
      if (sel[i]) begin
        mux_dat   = cl_dat[i];
        mux_dst   = cl_dst_ip[i];
        mux_proto = cl_proto[i];
        mux_len   = cl_payload_len[i];
        mux_bcast = cl_broadcast[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sel    <= '0;
      cool   <= 1'b0;
      tx.rdy <= 1'b0;
      tx.val <= 1'b0;
      tx.eof <= 1'b0;
    end else begin
      cool <= tx.done;
      if (tx.done) sel <= '0;
      else if (!busy && !cool) sel <= pick;
      tx.rdy <= |(sel & cl_rdy) && !tx.done;
      tx.val <= |(sel & cl_val);
      tx.eof <= |(sel & cl_val & cl_eof);
    end
  end

  // Payload and fields through one register stage
  always_ff @(posedge clk) begin
    tx.dat         <= mux_dat;
    tx.dst_ip      <= mux_dst;
    tx.proto       <= mux_proto;
    tx.payload_len <= mux_len;
    tx.broadcast   <= mux_bcast;
  end

  assert property (@(posedge clk) disable iff (fsm_rst) $onehot0(sel));

endmodule

/* logic/ipv4_tx.sv */
module ipv4_tx import ipv4_pkg::*; (
  input  logic       clk,
  input  logic       fsm_rst,
  input  ipv4_t      dev_ipv4,
  ipv4_tx_if.snk     tx,
  output ipv4_t      arp_ipv4_req,   // Non-zero only while a lookup is pending
  input  mac_addr_t  arp_mac_rsp,
  input  logic       arp_val,
  input  logic       arp_err,
  output logic [7:0] mac_tx_dat,
  output logic       mac_tx_val,
  output logic       mac_tx_sof,
  output logic       mac_tx_eof,
  output mac_addr_t  mac_tx_dst_mac
);

  tx_state_t state;

  logic [IPV4_HDR_LEN-1:0][7:0] hdr;  // Next byte out is hdr[19]
  logic [4:0]  cnt;
  logic [15:0] id;
  logic [15:0] chk_sum;
  logic        bcast;
  logic        load;

  // Hold off while our own done is out, rdy lags it by a cycle
  assign load = (state == TX_IDLE) && tx.rdy && !tx.done;

  ipv4_chsum u_chsum (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .clear    (state == TX_IDLE),
    .byte_val (state == TX_CALC),
    .dat      (hdr[IPV4_HDR_LEN-1]),
    .sum      (chk_sum)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= TX_IDLE;
      cnt          <= '0;
      id           <= '0;
      bcast        <= 1'b0;
      arp_ipv4_req <= '0;
      tx.req       <= 1'b0;
      tx.done      <= 1'b0;
      mac_tx_val   <= 1'b0;
      mac_tx_sof   <= 1'b0;
      mac_tx_eof   <= 1'b0;
    end else begin
      tx.req     <= 1'b0;
      tx.done    <= 1'b0;
      mac_tx_val <= 1'b0;
      mac_tx_sof <= 1'b0;
      mac_tx_eof <= 1'b0;
      case (state)
        TX_IDLE: begin
          if (load) begin
            bcast <= tx.broadcast;
            cnt   <= '0;
            state <= TX_CALC;
          end
        end
        TX_CALC: begin
          cnt <= cnt + 5'd1;
          if (cnt == 5'(IPV4_HDR_LEN - 1)) begin
            cnt          <= '0;
            state        <= TX_ARP;
            arp_ipv4_req <= bcast ? '0 : tx.dst_ip;
          end
        end
        TX_ARP: begin
          if (bcast || arp_val) begin
            arp_ipv4_req <= '0;
            state        <= TX_HEADER;
          end else if (arp_err) begin
            // No MAC for this address, drop the packet
            arp_ipv4_req <= '0;
            tx.done      <= 1'b1;
            state        <= TX_IDLE;
          end
        end
        TX_HEADER: begin
          mac_tx_val <= 1'b1;
          mac_tx_sof <= (cnt == 5'd0);
          tx.req     <= (cnt == 5'(IPV4_HDR_LEN - 2)); // Payload lands after the last header byte
          cnt        <= cnt + 5'd1;
          if (cnt == 5'(IPV4_HDR_LEN - 1)) state <= TX_PAYLOAD;
        end
        TX_PAYLOAD: begin
          if (mac_tx_eof) begin
            tx.done <= 1'b1;
            id      <= id + 16'd1;   // Only frames that went out
            state   <= TX_IDLE;
          end else begin
            mac_tx_val <= tx.val;
            mac_tx_eof <= tx.val && tx.eof;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      TX_IDLE: begin
        if (load) begin
          hdr <= {IPV4_VER, IPV4_IHL, 8'h00,
                  tx.payload_len + length_t'(IPV4_HDR_LEN), id,
                  IPV4_FLAGS_DF, 8'h00, IPV4_TTL, tx.proto,
                  16'h0000, dev_ipv4, tx.dst_ip};
        end
      end
      // Rotate so the header is back in order after 20 bytes
      TX_CALC: hdr <= {hdr[IPV4_HDR_LEN-2:0], hdr[IPV4_HDR_LEN-1]};
      TX_ARP: begin
        hdr[9:8] <= ~chk_sum;
        if (bcast) mac_tx_dst_mac <= '1;
        else if (arp_val) mac_tx_dst_mac <= arp_mac_rsp;
      end
      TX_HEADER: hdr <= {hdr[IPV4_HDR_LEN-2:0], 8'h00};
      default: ;
    endcase
    mac_tx_dat <= (state == TX_HEADER) ? hdr[IPV4_HDR_LEN-1] : tx.dat;
  end

  // Output is registered, so this also covers the cycle after leaving payload
  assert property (@(posedge clk) disable iff (fsm_rst)
    (state inside {TX_IDLE, TX_CALC, TX_ARP}) |-> !mac_tx_val);

endmodule

/* logic/ipv4_rx.sv */
module ipv4_rx import ipv4_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  ipv4_t       dev_ipv4,
  input  logic [7:0]  mac_rx_dat,
  input  logic        mac_rx_val,
  input  logic        mac_rx_sof,
  input  logic        mac_rx_eof,
  input  logic        mac_rx_err,
  input  logic [15:0] mac_rx_ethertype,
  output logic [7:0]  rx_dat,
  output logic        rx_val,
  output logic        rx_sof,
  output logic        rx_eof,
  output logic        rx_err,
  output ipv4_t       rx_src_ip,
  output proto_t      rx_proto,
  output length_t     rx_payload_len
);

  rx_state_t state;
  rx_state_t pay_next;

  logic [IPV4_HDR_LEN-1:0][7:0] hdr;  // First byte ends up in hdr[19]
  logic [4:0]  hdr_cnt;
  logic [15:0] chk_sum;
  length_t     tot_len, new_len, rem, cur_rem, cur_len;
  ipv4_t       dst_ip;
  logic        start, hdr_full, hdr_take, hdr_ok, accept, in_pay, take, last;

  assign start    = mac_rx_val && mac_rx_sof;
  assign hdr_full = (state == RX_HEADER) && (hdr_cnt == 5'(IPV4_HDR_LEN));
  assign hdr_take = mac_rx_val && (start || ((state == RX_HEADER) && !hdr_full));

  assign tot_len = hdr[17:16];
  assign new_len = tot_len - length_t'(IPV4_HDR_LEN);
  assign dst_ip  = hdr[3:0];

  // Checksum result is ready in the cycle after byte 20
  assign hdr_ok = (hdr[19] == {IPV4_VER, IPV4_IHL}) &&
                  (chk_sum == 16'hFFFF) &&
                  (tot_len > length_t'(IPV4_HDR_LEN)) &&
                  ((dst_ip == dev_ipv4) || (dst_ip == IPV4_BROADCAST));

  assign accept  = hdr_full && hdr_ok;
  assign in_pay  = accept || (state == RX_PAYLOAD);
  assign take    = in_pay && mac_rx_val && !mac_rx_err;
  assign cur_rem = accept ? new_len : rem;
  assign cur_len = accept ? new_len : rx_payload_len;
  assign last    = take && (cur_rem == 16'd1);

  always_comb begin
    if (mac_rx_eof) pay_next = RX_IDLE;
    else if (mac_rx_err || last) pay_next = RX_DROP;  // Skip padding or the broken rest
    else pay_next = RX_PAYLOAD;
  end

  ipv4_chsum u_chsum (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .clear    (start),
    .byte_val (hdr_take),
    .dat      (mac_rx_dat),
    .sum      (chk_sum)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= RX_IDLE;
      hdr_cnt <= '0;
    end else if (start) begin
      hdr_cnt <= 5'd1;
      state   <= (mac_rx_ethertype == ETHERTYPE_IPV4) ? RX_HEADER : RX_DROP;
    end else begin
      case (state)
        RX_HEADER: begin
          if (hdr_take) hdr_cnt <= hdr_cnt + 5'd1;
          if (hdr_full && !hdr_ok) state <= mac_rx_eof ? RX_IDLE : RX_DROP;
          else if (hdr_full) state <= pay_next;
          else if (mac_rx_eof) state <= RX_IDLE; // Runt frame
        end
        RX_PAYLOAD: state <= pay_next;
        RX_DROP: if (mac_rx_eof) state <= RX_IDLE;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rx_dat <= mac_rx_dat;
    if (hdr_take) hdr <= {hdr[IPV4_HDR_LEN-2:0], mac_rx_dat};
    if (accept) begin
      rx_src_ip      <= hdr[7:4];
      rx_proto       <= proto_t'(hdr[10]);
      rx_payload_len <= new_len;
    end
    if (take) rem <= cur_rem - 16'd1;
    else if (accept) rem <= new_len;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_val <= 1'b0;
      rx_sof <= 1'b0;
      rx_eof <= 1'b0;
      rx_err <= 1'b0;
    end else begin
      rx_val <= take;
      rx_sof <= take && (cur_rem == cur_len);
      rx_eof <= last;
      rx_err <= in_pay && mac_rx_err;
    end
  end

  assert property (@(posedge clk) disable iff (fsm_rst) rx_sof |-> rx_val);

endmodule

/* logic/ipv4_chsum.sv */
module ipv4_chsum (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clear,     // Restart the sum, a byte in the same cycle is the first one
  input  logic        byte_val,
  input  logic [7:0]  dat,
  output logic [15:0] sum
);

  logic [15:0] acc;
  logic [7:0]  hi;      // High byte of the pending word
  logic        odd;     // High byte held, waiting for low byte
  logic [16:0] add;

  assign add = {1'b0, acc} + {1'b0, hi, dat};
  assign sum = acc;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      acc <= '0;
      odd <= 1'b0;
    end else if (clear) begin
      acc <= '0;
      odd <= byte_val;
    end else if (byte_val) begin
      odd <= !odd;
      if (odd) acc <= add[15:0] + {15'd0, add[16]}; // End-around carry
    end
  end

  always_ff @(posedge clk) begin
    if (byte_val && (clear || !odd)) hi <= dat;
  end

endmodule

/* logic/ipv4_tx_if.sv */
interface ipv4_tx_if import ipv4_pkg::*; ();

  logic [7:0] dat;
  logic       val;
  logic       eof;
  logic       rdy;          // Selected client has a packet
  ipv4_t      dst_ip;
  proto_t     proto;
  length_t    payload_len;
  logic       broadcast;
  logic       req;          // Start payload stream
  logic       done;         // Packet sent or aborted

  // Arbiter side
  modport src (output dat, val, eof, rdy, dst_ip, proto, payload_len, broadcast,
               input  req, done);

  // Transmitter side
  modport snk (input  dat, val, eof, rdy, dst_ip, proto, payload_len, broadcast,
               output req, done);

endinterface

/* logic/ipv4_pkg.sv */
package ipv4_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] length_t;

  // Known protocols only, other codes are carried as raw values
  typedef enum logic [7:0] {
    PROTO_ICMP = 8'd1,
    PROTO_TCP  = 8'd6,
    PROTO_UDP  = 8'd17
  } proto_t;

  localparam int        IPV4_HDR_LEN   = 20;  // Bytes, no options
  localparam logic [3:0] IPV4_VER      = 4'd4;
  localparam logic [3:0] IPV4_IHL      = 4'd5; // Words
  localparam logic [7:0] IPV4_TTL      = 8'd64;
  localparam logic [7:0] IPV4_FLAGS_DF = 8'h40;
  localparam ipv4_t     IPV4_BROADCAST = 32'hFFFF_FFFF;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  localparam int N_CLIENT = 3; // Transmit clients on the arbiter

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HEADER,
    RX_PAYLOAD,
    RX_DROP
  } rx_state_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_CALC,
    TX_ARP,
    TX_HEADER,
    TX_PAYLOAD
  } tx_state_t;

endpackage
